// File: design/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// register index width
`define PIPE_REG_ADDR_W 5

// instruction tag carried down the pipe
`define PIPE_TAG_W 8

`define PIPE_MULDIV_CYCLES 4  // cycles a mul/div occupies EX

`define PIPE_STAGES 6  // PC, IF/ID, ID/EX, EX/MEM, MEM/WB, WB

`endif

// File: design/pipe_pkg.sv
`default_nettype none

`include "pipe_settings.svh"

package pipe_pkg;

  // one bit per stage register, bit 0 is PC
  typedef logic [`PIPE_STAGES-1:0] stage_vec_t;

  // IF/ID payload
  typedef struct packed {
    logic                        valid;
    logic [`PIPE_TAG_W-1:0]      tag;
    logic [`PIPE_REG_ADDR_W-1:0] rd;
    logic [`PIPE_REG_ADDR_W-1:0] rs1;
    logic [`PIPE_REG_ADDR_W-1:0] rs2;
    logic                        is_load;
    logic                        is_muldiv;
  } fetch_info_t;

  typedef struct packed {
    logic                        valid;
    logic [`PIPE_TAG_W-1:0]      tag;
    logic [`PIPE_REG_ADDR_W-1:0] rd;
    logic                        is_load;
    logic                        is_muldiv;
  } ex_info_t;  // ID/EX payload, sources dropped

  typedef struct packed {
    logic                        valid;
    logic [`PIPE_TAG_W-1:0]      tag;
    logic [`PIPE_REG_ADDR_W-1:0] rd;
  } retire_info_t;  // EX/MEM and MEM/WB

  typedef struct packed {
    logic load_use;
    logic jump;
  } hazard_req_t;

  typedef struct packed {
    logic if_wait;     // imem not ready
    logic mem_wait;    // dmem not ready
    logic muldiv;      // EX occupied by mul/div
    logic trap_flush;
    logic trap_stall;
  } busy_req_t;

endpackage

`default_nettype wire

// File: design/hazard_detect.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_detect (
  input  pipe_pkg::fetch_info_t id_info_i,
  input  pipe_pkg::ex_info_t    ex_info_i,
  input  logic                  jump_taken_i,
  output pipe_pkg::hazard_req_t req_o
);

  logic ex_load;  // valid load writing a real register
  logic rs1_hit;
  logic rs2_hit;

  // x0 is never a true dependency
  always_comb begin
    ex_load = ex_info_i.valid && ex_info_i.is_load && (ex_info_i.rd != '0);
  end

  always_comb begin
    rs1_hit = (ex_info_i.rd == id_info_i.rs1);
    rs2_hit = (ex_info_i.rd == id_info_i.rs2);
  end

  always_comb begin
    req_o          = '0;
    req_o.load_use = ex_load && id_info_i.valid && (rs1_hit || rs2_hit);
    // taken jump resolves in EX, forwarded as is
    req_o.jump     = jump_taken_i;
  end

  // the load-use bubble lasts one cycle since the load then
  // moves to EX/MEM and the comparison no longer matches

endmodule

`default_nettype wire

// File: design/busy_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "pipe_settings.svh"

module busy_tracker (
  input  logic                clk,
  input  logic                rst,
  input  logic                ex_muldiv_i,   // valid mul/div in ID/EX
  input  logic                imem_wait_i,
  input  logic                dmem_wait_i,
  input  logic                trap_flush_i,
  input  logic                trap_stall_i,
  output pipe_pkg::busy_req_t req_o
);

  localparam int CNT_W = $clog2(`PIPE_MULDIV_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PIPE_MULDIV_CYCLES - 1);

  logic [CNT_W-1:0] cnt;  // busy cycles seen so far
  logic             done; // release cycle for the held op

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (done) begin
      // op leaves EX this cycle, next one starts clean
      done <= 1'b0;
      cnt  <= '0;
    end else if (ex_muldiv_i) begin
      if (cnt == CNT_LAST) begin
        cnt  <= '0;
        done <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else begin
      cnt <= '0;  // op flushed away mid count
    end
  end

  // all other requests are plain levels
  always_comb begin
    req_o            = '0;
    req_o.if_wait    = imem_wait_i;
    req_o.mem_wait   = dmem_wait_i;
    req_o.muldiv     = ex_muldiv_i && !done;
    req_o.trap_flush = trap_flush_i;
    req_o.trap_stall = trap_stall_i;
  end

  // with a mul/div arriving while cnt is zero, muldiv stays high
  // for cycles 0 .. PIPE_MULDIV_CYCLES-1 and drops in the done cycle

endmodule

`default_nettype wire

// File: design/pipeline_control.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_control (
  input  logic                  rst,
  input  pipe_pkg::hazard_req_t hazard_i,
  input  pipe_pkg::busy_req_t   busy_i,
  output pipe_pkg::stage_vec_t  stall_o,
  output pipe_pkg::stage_vec_t  flush_o
);

  import pipe_pkg::*;

  // bit order: WB, MEM/WB, EX/MEM, ID/EX, IF/ID, PC
  localparam stage_vec_t RST_STALL      = 6'b000000;
  localparam stage_vec_t RST_FLUSH      = 6'b011111;  // clear every stage register

  localparam stage_vec_t DMEM_STALL     = 6'b001111;  // freeze up to EX/MEM
  localparam stage_vec_t DMEM_FLUSH     = 6'b010000;  // bubble into MEM/WB

  localparam stage_vec_t IMEM_STALL     = 6'b000011;  // hold PC and IF/ID
  localparam stage_vec_t IMEM_FLUSH     = 6'b000000;

  localparam stage_vec_t TRAP_FL_STALL  = 6'b000010;
  localparam stage_vec_t TRAP_FL_FLUSH  = 6'b001110;

  localparam stage_vec_t TRAP_ST_STALL  = 6'b111111;  // whole pipe frozen
  localparam stage_vec_t TRAP_ST_FLUSH  = 6'b001110;

  localparam stage_vec_t JUMP_STALL     = 6'b000010;
  localparam stage_vec_t JUMP_FLUSH     = 6'b000110;  // kill wrong-path IF/ID and ID/EX

  localparam stage_vec_t MULDIV_STALL   = 6'b000111;  // hold op in ID/EX
  localparam stage_vec_t MULDIV_FLUSH   = 6'b001000;

  localparam stage_vec_t LOAD_USE_STALL = 6'b000011;
  localparam stage_vec_t LOAD_USE_FLUSH = 6'b000100;  // bubble behind the load

  localparam stage_vec_t NONE           = 6'b000000;

  // memory waits first, then traps, jump, mul/div and load-use
  always_comb begin
    if (rst) begin
      stall_o = RST_STALL;
      flush_o = RST_FLUSH;
    end else if (busy_i.mem_wait) begin
      // covers dmem alone and dmem with imem
      stall_o = DMEM_STALL;
      flush_o = DMEM_FLUSH;
    end else if (busy_i.if_wait) begin
      stall_o = IMEM_STALL;
      flush_o = IMEM_FLUSH;
    end else if (busy_i.trap_flush) begin
      stall_o = TRAP_FL_STALL;
      flush_o = TRAP_FL_FLUSH;
    end else if (busy_i.trap_stall) begin
      stall_o = TRAP_ST_STALL;
      flush_o = TRAP_ST_FLUSH;
    end else if (hazard_i.jump) begin
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (busy_i.muldiv) begin
      stall_o = MULDIV_STALL;
      flush_o = MULDIV_FLUSH;
    end else if (hazard_i.load_use) begin
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end else begin
      stall_o = NONE;
      flush_o = NONE;
    end
  end

  // in the trap rows and the jump row some stages are both stalled
  // and flushed, and the stage register lets flush win

endmodule

`default_nettype wire

// File: design/pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // flush beats stall, all zeros is a bubble
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      q_o <= '0;
    end else if (!stall_i) begin
      q_o <= d_i;  // advance one stage
    end
  end

  // stall with no flush keeps q_o unchanged

endmodule

`default_nettype wire

// File: design/pipe_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl_top (
  input  logic                   clk,
  input  logic                   rst,
  input  pipe_pkg::fetch_info_t  fetch_info_i,
  input  logic                   jump_taken_ex_i,
  input  logic                   imem_wait_i,
  input  logic                   dmem_wait_i,
  input  logic                   trap_flush_wb_i,
  input  logic                   trap_stall_wb_i,
  output pipe_pkg::stage_vec_t   stall_o,
  output pipe_pkg::stage_vec_t   flush_o,
  output pipe_pkg::fetch_info_t  id_info_o,
  output pipe_pkg::ex_info_t     ex_info_o,
  output pipe_pkg::retire_info_t mem_info_o,
  output pipe_pkg::retire_info_t wb_info_o
);

  import pipe_pkg::*;

  hazard_req_t  hazard_req;
  busy_req_t    busy_req;
  ex_info_t     ex_d;       // IF/ID narrowed for ID/EX
  retire_info_t mem_d;      // ID/EX narrowed for EX/MEM

  always_comb begin
    ex_d.valid     = id_info_o.valid;
    ex_d.tag       = id_info_o.tag;
    ex_d.rd        = id_info_o.rd;
    ex_d.is_load   = id_info_o.is_load;
    ex_d.is_muldiv = id_info_o.is_muldiv;
  end

  always_comb begin
    mem_d.valid = ex_info_o.valid;
    mem_d.tag   = ex_info_o.tag;
    mem_d.rd    = ex_info_o.rd;
  end

  hazard_detect u_hazard (
    .id_info_i    (id_info_o),
    .ex_info_i    (ex_info_o),
    .jump_taken_i (jump_taken_ex_i),
    .req_o        (hazard_req)
  );

  busy_tracker u_busy (
    .clk          (clk),
    .rst          (rst),
    .ex_muldiv_i  (ex_info_o.valid && ex_info_o.is_muldiv),
    .imem_wait_i  (imem_wait_i),
    .dmem_wait_i  (dmem_wait_i),
    .trap_flush_i (trap_flush_wb_i),
    .trap_stall_i (trap_stall_wb_i),
    .req_o        (busy_req)
  );

  pipeline_control u_ctrl (
    .rst      (rst),
    .hazard_i (hazard_req),
    .busy_i   (busy_req),
    .stall_o  (stall_o),
    .flush_o  (flush_o)
  );

  // bit 0 (PC) and bit 5 (WB) leave through the ports only
  pipe_reg #(.payload_t(fetch_info_t)) if_id_reg (
    .clk (clk), .rst (rst), .stall_i (stall_o[1]), .flush_i (flush_o[1]),
    .d_i (fetch_info_i), .q_o (id_info_o)
  );

  pipe_reg #(.payload_t(ex_info_t)) id_ex_reg (
    .clk (clk), .rst (rst), .stall_i (stall_o[2]), .flush_i (flush_o[2]),
    .d_i (ex_d), .q_o (ex_info_o)
  );

  pipe_reg #(.payload_t(retire_info_t)) ex_mem_reg (
    .clk (clk), .rst (rst), .stall_i (stall_o[3]), .flush_i (flush_o[3]),
    .d_i (mem_d), .q_o (mem_info_o)
  );

  pipe_reg #(.payload_t(retire_info_t)) mem_wb_reg (
    .clk (clk), .rst (rst), .stall_i (stall_o[4]), .flush_i (flush_o[4]),
    .d_i (mem_info_o), .q_o (wb_info_o)
  );

endmodule

`default_nettype wire

// File: sim/pipe_ctrl_assert.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl_assert (
  input logic                  clk,
  input logic                  rst,
  input pipe_pkg::hazard_req_t hazard_i,
  input pipe_pkg::busy_req_t   busy_i,
  input pipe_pkg::stage_vec_t  stall_i,
  input pipe_pkg::stage_vec_t  flush_i
);

  // priority rows, row 0 highest, row 7 is the idle row
  localparam logic [7:0][5:0] STALL_TAB = {6'b000000, 6'b000011, 6'b000111, 6'b000010,
                                           6'b111111, 6'b000010, 6'b000011, 6'b001111};
  localparam logic [7:0][5:0] FLUSH_TAB = {6'b000000, 6'b000100, 6'b001000, 6'b000110,
                                           6'b001110, 6'b001110, 6'b000000, 6'b010000};

  int         fail_cnt = 0;
  logic [7:0] req;  // one bit per row
  logic [7:0] hit;  // one-hot winning row

  always_comb begin
    req = {1'b1, hazard_i.load_use, busy_i.muldiv, hazard_i.jump,
           busy_i.trap_stall, busy_i.trap_flush, busy_i.if_wait, busy_i.mem_wait};
    hit = rst ? 8'h00 : (req & (~req + 8'd1));  // lowest set bit wins
  end

  reset_vecs: assert property (@(posedge clk) rst |-> (stall_i == '0 && flush_i == 6'b011111))
    else begin
      $error("reset gave stall %b flush %b", $sampled(stall_i), $sampled(flush_i));
      fail_cnt++;
    end

  for (genvar r = 0; r < 8; r++) begin : g_row
    row_vecs: assert property (@(posedge clk)
                               hit[r] |-> (stall_i == STALL_TAB[r] && flush_i == FLUSH_TAB[r]))
      else begin
        $error("row %0d gave stall %b flush %b", r, $sampled(stall_i), $sampled(flush_i));
        fail_cnt++;
      end
  end

endmodule

`default_nettype wire

// File: sim/pipe_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "pipe_settings.svh"

module pipe_ctrl_tb;

  import pipe_pkg::*;

  localparam int         MAX_CYCLES   = 400;  // limit for the whole run
  localparam stage_vec_t MULDIV_STALL = 6'b000111;

  logic         clk;
  logic         rst;
  fetch_info_t  fetch_info;
  logic         jump_taken, imem_wait, dmem_wait, trap_flush, trap_stall;
  stage_vec_t   stall, flush;
  fetch_info_t  id_info;
  ex_info_t     ex_info;
  retire_info_t mem_info, wb_info;

  integer                 seed = 87;
  int                     cycles = 0;
  int                     stage_errs = 0;
  int                     errs_before = 0;
  int                     tests_failed = 0;
  int                     busy_cycles;
  logic [`PIPE_TAG_W-1:0] tag_a, tag_b;

  pipe_ctrl_top dut (
    .clk (clk), .rst (rst), .fetch_info_i (fetch_info), .jump_taken_ex_i (jump_taken),
    .imem_wait_i (imem_wait), .dmem_wait_i (dmem_wait), .trap_flush_wb_i (trap_flush),
    .trap_stall_wb_i (trap_stall), .stall_o (stall), .flush_o (flush), .id_info_o (id_info),
    .ex_info_o (ex_info), .mem_info_o (mem_info), .wb_info_o (wb_info)
  );

  bind pipeline_control pipe_ctrl_assert u_assert (
    .clk (pipe_ctrl_tb.clk), .rst (rst), .hazard_i (hazard_i), .busy_i (busy_i),
    .stall_i (stall_o), .flush_i (flush_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [`PIPE_TAG_W-1:0] rand_tag();
    integer r;
    r = $random(seed);
    return r[`PIPE_TAG_W-1:0];
  endfunction

  function automatic logic [`PIPE_REG_ADDR_W-1:0] rand_reg();
    integer r;
    r = $random(seed);
    r[0] = 1'b1;  // never x0
    return r[`PIPE_REG_ADDR_W-1:0];
  endfunction

  function automatic fetch_info_t make_op(input logic [`PIPE_TAG_W-1:0] tag,
                                          input logic [`PIPE_REG_ADDR_W-1:0] rd,
                                          input logic [`PIPE_REG_ADDR_W-1:0] rs1,
                                          input logic ld, input logic md);
    fetch_info_t op;
    op           = '0;
    op.valid     = 1'b1;
    op.tag       = tag;
    op.rd        = rd;
    op.rs1       = rs1;
    op.rs2       = rand_reg();
    op.is_load   = ld;
    op.is_muldiv = md;
    return op;
  endfunction

  task automatic issue(input fetch_info_t op);
    @(posedge clk);
    fetch_info <= op;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  // returns right after the edge that puts the load in EX and its user in ID
  task automatic issue_load_pair(input logic [`PIPE_REG_ADDR_W-1:0] rd,
                                 output logic [`PIPE_TAG_W-1:0] use_tag);
    use_tag = rand_tag();
    issue(make_op(rand_tag(), rd, rand_reg(), 1'b1, 1'b0));
    issue(make_op(use_tag, rand_reg(), rd, 1'b0, 1'b0));
    issue('0);
  endtask

  task automatic check_stage(input string where, input logic vld,
                             input logic [`PIPE_TAG_W-1:0] tag, input logic exp_vld,
                             input logic [`PIPE_TAG_W-1:0] exp_tag);
    if (vld !== exp_vld || (exp_vld && tag !== exp_tag)) begin
      $display("MISMATCH at %0t: %s valid %b tag %h, expected valid %b tag %h",
               $time, where, vld, tag, exp_vld, exp_tag);
      stage_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs        = stage_errs + dut.u_ctrl.u_assert.fail_cnt - errs_before;
    errs_before = stage_errs + dut.u_ctrl.u_assert.fail_cnt;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errs);
    end
  endtask

  initial begin
    rst        = 1'b1;
    fetch_info = '0;
    jump_taken = 1'b0;
    imem_wait  = 1'b0;
    dmem_wait  = 1'b0;
    trap_flush = 1'b0;
    trap_stall = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    tag_a = rand_tag();
    issue(make_op(tag_a, rand_reg(), rand_reg(), 1'b0, 1'b0));
    issue('0);
    @(negedge clk);
    check_stage("id", id_info.valid, id_info.tag, 1'b1, tag_a);
    next_cycle();
    check_stage("ex", ex_info.valid, ex_info.tag, 1'b1, tag_a);
    next_cycle();
    check_stage("mem", mem_info.valid, mem_info.tag, 1'b1, tag_a);
    next_cycle();
    check_stage("wb", wb_info.valid, wb_info.tag, 1'b1, tag_a);
    finish_test("reset and free flow");

    issue_load_pair(rand_reg(), tag_b);
    next_cycle();  // bubble goes into ID/EX
    check_stage("ex bubble", ex_info.valid, ex_info.tag, 1'b0, '0);
    check_stage("id held", id_info.valid, id_info.tag, 1'b1, tag_b);
    next_cycle();
    check_stage("ex late", ex_info.valid, ex_info.tag, 1'b1, tag_b);
    issue_load_pair('0, tag_b);  // x0 load, no stall
    @(negedge clk);
    next_cycle();
    check_stage("ex x0", ex_info.valid, ex_info.tag, 1'b1, tag_b);
    finish_test("load-use");

    tag_a = rand_tag();
    issue(make_op(tag_a, rand_reg(), rand_reg(), 1'b0, 1'b0));
    issue(make_op(rand_tag(), rand_reg(), rand_reg(), 1'b0, 1'b0));
    issue('0);
    jump_taken <= 1'b1;
    @(posedge clk);
    jump_taken <= 1'b0;
    @(negedge clk);
    check_stage("id killed", id_info.valid, id_info.tag, 1'b0, '0);
    check_stage("ex killed", ex_info.valid, ex_info.tag, 1'b0, '0);
    check_stage("mem jump", mem_info.valid, mem_info.tag, 1'b1, tag_a);
    finish_test("jump");

    tag_a = rand_tag();
    issue(make_op(tag_a, rand_reg(), rand_reg(), 1'b0, 1'b1));
    issue('0);
    next_cycle();  // op now in EX
    busy_cycles = 0;
    while (stall == MULDIV_STALL) begin
      busy_cycles++;
      next_cycle();
    end
    if (busy_cycles != `PIPE_MULDIV_CYCLES) begin
      $display("MISMATCH at %0t: mul/div stall lasted %0d cycles, expected %0d",
               $time, busy_cycles, `PIPE_MULDIV_CYCLES);
      stage_errs++;
    end
    next_cycle();
    check_stage("mem muldiv", mem_info.valid, mem_info.tag, 1'b1, tag_a);
    finish_test("mul/div");

    tag_a = rand_tag();
    issue(make_op(tag_a, rand_reg(), rand_reg(), 1'b0, 1'b0));
    issue('0);
    dmem_wait <= 1'b1;
    @(posedge clk);
    imem_wait <= 1'b1;
    @(posedge clk);
    dmem_wait <= 1'b0;
    @(posedge clk);
    jump_taken <= 1'b1;  // imem wait must mask it
    @(posedge clk);
    imem_wait  <= 1'b0;
    jump_taken <= 1'b0;
    @(negedge clk);
    check_stage("id held", id_info.valid, id_info.tag, 1'b1, tag_a);
    finish_test("memory waits");

    issue_load_pair(rand_reg(), tag_b);
    trap_flush <= 1'b1;
    trap_stall <= 1'b1;
    @(posedge clk);
    trap_flush <= 1'b0;
    trap_stall <= 1'b0;
    @(negedge clk);
    check_stage("id trap flush", id_info.valid, id_info.tag, 1'b0, '0);
    check_stage("ex trap flush", ex_info.valid, ex_info.tag, 1'b0, '0);
    issue_load_pair(rand_reg(), tag_b);
    trap_stall <= 1'b1;
    @(posedge clk);
    trap_stall <= 1'b0;
    @(negedge clk);
    check_stage("id trap stall", id_info.valid, id_info.tag, 1'b0, '0);
    check_stage("ex trap stall", ex_info.valid, ex_info.tag, 1'b0, '0);
    next_cycle();
    finish_test("traps");

    $display("tests 6, failed %0d, stage mismatches %0d, assertion failures %0d",
             tests_failed, stage_errs, dut.u_ctrl.u_assert.fail_cnt);
    if (tests_failed == 0 && stage_errs == 0 && dut.u_ctrl.u_assert.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/pipe_pkg.sv
design/hazard_detect.sv
design/busy_tracker.sv
design/pipeline_control.sv
design/pipe_reg.sv
design/pipe_ctrl_top.sv
sim/pipe_ctrl_assert.sv
sim/pipe_ctrl_tb.sv
